// ==== boot_rom.hex ====
// boot rom image, one byte per line, rom offsets 0x00 to 0x1F in order
// reset code at 0x00, irq handler at 0x11, nmi/reset/irq vectors at 0x1A
A2
FF
9A
A9
00
8D
00
C0
AD
01
C0
8D
00
C0
4C
08
F0
40
EA
EA
EA
EA
EA
EA
EA
EA
11
F0
00
F0
11
F0

// ==== project.f ====
+incdir+include
src/bus_pkg.sv
src/memory_mapper.sv
src/addr_decode.sv
src/bus_ram.sv
src/boot_rom.sv
src/board_io.sv
src/irq_ctrl.sv
src/cpu_bus_top.sv
tb/tb_cpu_bus_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, status follows the result line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_cpu_bus_top &&
./obj_dir/Vtb_cpu_bus_top | tee /dev/stderr | grep -x "Test passed" > /dev/null ||
{ echo "simulation did not pass"; exit 1; }

// ==== tb/tb_cpu_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module tb_cpu_bus_top import bus_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int RAM_OPS        = 400;

    logic       clk;
    logic       rst;
    cpu_bus_t   bus;
    logic [7:0] sw;
    logic       button_n;
    logic       ext_irq;
    logic [7:0] rd_data;
    logic       rd_valid;
    logic [7:0] led;
    logic       irqb;

    // reference model state
    logic [11:0] slot_m [`BUS_MM_SLOTS];
    logic [7:0]  ram_m [2 ** `BUS_RAM_BITS];
    logic [7:0]  rom_m [2 ** `BUS_ROM_BITS];
    logic [7:0]  led_m;
    logic [7:0]  flags_m;

    logic [7:0]  exp_q [$];         // expected data of reads in flight
    logic [15:0] addr_q [$];
    logic [15:0] written_q [$];     // ram addresses with known contents

    int chk_errors = 0;
    int rd_errors  = 0;
    int rd_checks  = 0;
    int checks     = 0;
    int tests      = 0;
    int test_base  = 0;

    cpu_bus_top dut_i (
        .clk(clk), .rst(rst), .i_bus(bus), .i_sw(sw),
        .i_button_n(button_n), .i_ext_irq(ext_irq),
        .o_rd_data(rd_data), .o_rd_valid(rd_valid), .o_led(led), .o_irqb(irqb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [7:0] expected_read(input logic [15:0] addr);
        phys_addr_t phys;
        logic [7:0] val;
        phys = {slot_m[addr[15:12]], addr[11:0]};
        val  = 8'hFF;                                   // unmapped
        if (phys[23:`BUS_RAM_BITS] == '0) begin
            val = ram_m[phys[`BUS_RAM_BITS-1:0]];
        end else if (phys[23:12] == 12'h00F) begin
            val = rom_m[addr[4:0]];                     // 32-byte mirror
        end else if (phys[23:8] == 16'h00C0) begin
            if (phys[7:0] == 8'h00) begin
                val = led_m;
            end else if (phys[7:0] == 8'h01) begin
                val = sw;
            end else if (phys[7:0] == 8'h04) begin
                val = flags_m;
            end else if (phys[7:4] == 4'h1) begin
                val = slot_m[phys[3:0]][7:0];
            end else if (phys[7:4] == 4'h2) begin
                val = {4'h0, slot_m[phys[3:0]][11:8]};
            end
        end
        return val;
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
        phys_addr_t phys;
        phys = {slot_m[addr[15:12]], addr[11:0]};
        if (phys[23:`BUS_RAM_BITS] == '0) begin
            ram_m[phys[`BUS_RAM_BITS-1:0]] = data;
        end else if (phys[23:8] == 16'h00C0) begin
            if (phys[7:0] == 8'h00) begin
                led_m = data;
            end else if (phys[7:0] == 8'h04) begin
                flags_m = flags_m & data;
            end else if (phys[7:4] == 4'h1) begin
                slot_m[phys[3:0]][7:0] = data;
            end else if (phys[7:4] == 4'h2) begin
                slot_m[phys[3:0]][11:8] = data[3:0];
            end
        end
    endfunction

    // driven on a falling edge until the next one
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus.valid = 1'b1;
        bus.rwb   = 1'b0;
        bus.addr  = addr;
        bus.wdata = data;
        model_write(addr, data);
        @(negedge clk);
        bus.valid = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr);
        int waited;
        bus.valid = 1'b1;
        bus.rwb   = 1'b1;
        bus.addr  = addr;
        bus.wdata = 8'h00;
        exp_q.push_back(expected_read(addr));
        addr_q.push_back(addr);
        @(negedge clk);
        bus.valid = 1'b0;
        waited = 0;
        while (!rd_valid && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            $display("timeout: no read data came back for address %h", addr);
            $display("Test failed");
            $finish;
        end else begin
            checks++;
            assert (waited == 0) else begin
                $display("read data for address %h came back %0d cycles late", addr, waited);
                chk_errors++;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
        checks++;
        assert (got === want) else begin
            $display("** Error %s: got %h, expected %h", name, got, want);
            chk_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int waited;
        int errs;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: reads still outstanding at the end of %s", name);
            $display("Test failed");
            $finish;
        end
        tests++;
        errs = chk_errors + rd_errors - test_base;
        test_base = chk_errors + rd_errors;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errs);
        end
    endtask

    // every returned byte against the model
    initial begin : compare_reads
        logic [7:0]  want;
        logic [15:0] a;
        forever begin
            @(negedge clk);
            if (rd_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("read data came back with no read outstanding");
                    rd_errors++;
                end else begin
                    want = exp_q.pop_front();
                    a    = addr_q.pop_front();
                    rd_checks++;
                    assert (rd_data === want) else begin
                        $display("** Error o_rd_data @%h: got %h, expected %h", a, rd_data, want);
                        rd_errors++;
                    end
                end
            end
        end
    end

    initial begin : run
        logic [15:0] a;
        logic [7:0]  d;
        int          pick;
        void'($urandom(32'h6508e1fa));
        rst      = 1'b1;
        bus      = '0;
        sw       = 8'h00;
        button_n = 1'b1;
        ext_irq  = 1'b0;
        for (int i = 0; i < `BUS_MM_SLOTS; i++) begin
            slot_m[i] = 12'(i);                         // identity map
        end
        led_m   = 8'h00;
        flags_m = 8'h00;
        $readmemh("boot_rom.hex", rom_m);
        repeat (10) @(negedge clk);
        rst = 1'b0;

        check_value("o_led", led, 8'h00);
        check_value("o_irqb", {7'h0, irqb}, 8'h01);
        for (int i = 0; i < 16; i++) begin
            bus_read(16'hC010 + 16'(i));
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(16'hC020 + 16'(i));
        end
        end_test("reset state");

        for (int n = 0; n < RAM_OPS; n++) begin
            pick = int'($urandom_range(0, 3));
            if (written_q.size() == 0 || pick <= 1) begin
                a = 16'($urandom_range(0, 32'h7FFF));
                bus_write(a, 8'($urandom));
                written_q.push_back(a);
                if (pick == 1) begin
                    bus_read(a);                        // read right behind the write
                end
            end else begin
                bus_read(written_q[$urandom_range(0, written_q.size() - 1)]);
            end
            if ($urandom_range(0, 7) == 0) begin
                @(negedge clk);
            end
        end
        end_test("ram random access");

        for (int i = 0; i < 32; i++) begin
            bus_read(16'hF000 + 16'(i));
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(16'($urandom_range(32'hF000, 32'hFFFF)));
        end
        end_test("boot rom");

        bus_write(16'h0ABC, 8'h3C);
        bus_write(16'h3ABC, 8'hC3);
        bus_write(16'hC012, 8'h05);
        bus_write(16'hC022, 8'h00);
        bus_read(16'hC012);
        bus_write(16'h2ABC, 8'h5A);
        bus_read(16'h5ABC);
        bus_read(16'h2ABC);
        bus_write(16'hC013, 8'h00);                     // slot 3 to page 0x100
        bus_write(16'hC023, 8'h01);
        bus_read(16'hC023);
        bus_read(16'h3ABC);
        bus_read(16'h3000);
        bus_write(16'h3ABC, 8'hEE);
        bus_read(16'h0ABC);
        bus_read(16'h3ABC);
        bus_write(16'hC013, 8'h03);
        bus_write(16'hC023, 8'h00);
        bus_read(16'h3ABC);
        bus_write(16'hC012, 8'h02);
        for (int i = 0; i < 16; i++) begin
            bus_read(written_q[$urandom_range(0, written_q.size() - 1)]);
        end
        end_test("remapping");

        for (int i = 0; i < 8; i++) begin
            d = 8'($urandom);
            bus_write(16'hC000, d);
            check_value("o_led", led, led_m);
            bus_read(16'hC000);
            sw = 8'($urandom);
            bus_read(16'hC001);
        end
        end_test("board io");

        ext_irq = 1'b1;
        @(negedge clk);
        ext_irq = 1'b0;
        flags_m[1] = 1'b1;
        button_n = 1'b0;
        repeat (3) @(negedge clk);
        flags_m[0] = 1'b1;
        check_value("o_irqb", {7'h0, irqb}, 8'h00);
        bus_read(16'hC004);
        button_n = 1'b1;
        @(negedge clk);
        bus_write(16'hC004, 8'hFE);
        bus_read(16'hC004);
        check_value("o_irqb", {7'h0, irqb}, 8'h00);
        bus_write(16'hC004, 8'h00);
        bus_read(16'hC004);
        check_value("o_irqb", {7'h0, irqb}, 8'h01);
        end_test("interrupts");

        $display("tests %0d, checks %0d, errors %0d", tests, checks + rd_checks,
                 chk_errors + rd_errors);
        if (chk_errors + rd_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/cpu_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_top import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire cpu_bus_t   i_bus,
    input  wire [7:0]       i_sw,
    input  wire             i_button_n,
    input  wire             i_ext_irq,
    output logic [7:0]      o_rd_data,
    output logic            o_rd_valid,
    output logic [7:0]      o_led,
    output logic            o_irqb
);

    phys_addr_t phys;

    logic ram_cs;
    logic rom_cs;
    logic io_cs;
    logic irq_cs;
    logic mm_lo_cs;
    logic mm_hi_cs;

    logic [7:0] ram_rd;
    logic [7:0] rom_rd;
    logic [7:0] io_rd;
    logic [7:0] irq_rd;
    logic [7:0] mm_rd;

    memory_mapper mapper_i (
        .clk(clk), .rst(rst), .i_bus(i_bus),
        .i_lo_cs(mm_lo_cs), .i_hi_cs(mm_hi_cs),
        .o_rd_data(mm_rd), .o_phys(phys)
    );

    addr_decode decode_i (
        .clk(clk), .rst(rst), .i_bus(i_bus), .i_phys(phys),
        .o_ram_cs(ram_cs), .o_rom_cs(rom_cs), .o_io_cs(io_cs),
        .o_irq_cs(irq_cs), .o_mm_lo_cs(mm_lo_cs), .o_mm_hi_cs(mm_hi_cs),
        .i_ram_rd(ram_rd), .i_rom_rd(rom_rd), .i_io_rd(io_rd),
        .i_irq_rd(irq_rd), .i_mm_rd(mm_rd),
        .o_rd_data(o_rd_data), .o_rd_valid(o_rd_valid)
    );

    bus_ram ram_i (
        .clk(clk), .i_cs(ram_cs), .i_bus(i_bus), .i_phys(phys), .o_rd_data(ram_rd)
    );

    boot_rom rom_i (
        .clk(clk), .i_cs(rom_cs), .i_bus(i_bus), .o_rd_data(rom_rd)
    );

    board_io io_i (
        .clk(clk), .rst(rst), .i_cs(io_cs), .i_bus(i_bus),
        .i_sw(i_sw), .o_led(o_led), .o_rd_data(io_rd)
    );

    irq_ctrl irq_i (
        .clk(clk), .rst(rst), .i_cs(irq_cs), .i_bus(i_bus),
        .i_button_n(i_button_n), .i_ext_irq(i_ext_irq),
        .o_irqb(o_irqb), .o_rd_data(irq_rd)
    );

endmodule

`default_nettype wire

// ==== src/irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_cs,
    input  wire cpu_bus_t   i_bus,
    input  wire             i_button_n,
    input  wire             i_ext_irq,
    output logic            o_irqb,
    output logic [7:0]      o_rd_data
);

    logic [7:0] flags_q;

    // sticky flags, cleared by writing a mask
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else if (i_cs && !i_bus.rwb) begin
            flags_q <= flags_q & i_bus.wdata;       // write wins over new sources
        end else begin
            if (!i_button_n) begin
                flags_q[0] <= 1'b1;
            end
            if (i_ext_irq) begin
                flags_q[1] <= 1'b1;
            end
        end
    end

    assign o_irqb = ~|flags_q;      // active low to the cpu

    always_ff @(posedge clk) begin
        if (i_cs && i_bus.rwb) begin
            o_rd_data <= flags_q;
        end
    end

    // cpu must come out of reset with no pending request
    a_irqb_after_rst: assert property (
        @(posedge clk)
        rst |=> o_irqb
    );

endmodule

`default_nettype wire

// ==== src/board_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_io import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_cs,
    input  wire cpu_bus_t   i_bus,
    input  wire [7:0]       i_sw,
    output logic [7:0]      o_led,
    output logic [7:0]      o_rd_data
);

    logic sw_sel;
    logic led_wr;

    assign sw_sel = i_bus.addr[0];                          // 0 = leds, 1 = switches
    assign led_wr = i_cs && !i_bus.rwb && !sw_sel;          // switch offset is read only

    always_ff @(posedge clk) begin
        if (rst) begin
            o_led <= '0;
        end else if (led_wr) begin
            o_led <= i_bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cs && i_bus.rwb) begin
            o_rd_data <= sw_sel ? i_sw : o_led;
        end
    end

endmodule

`default_nettype wire

// ==== src/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module boot_rom import bus_pkg::*; (
    input  wire             clk,
    input  wire             i_cs,
    input  wire cpu_bus_t   i_bus,
    output logic [7:0]      o_rd_data
);

    localparam int DEPTH = 2 ** `BUS_ROM_BITS;

    logic [7:0] rom [DEPTH];

    initial begin
        $readmemh("boot_rom.hex", rom);
    end

    // low address bits only, so the image repeats across the page
    always_ff @(posedge clk) begin
        if (i_cs && i_bus.rwb) begin
            o_rd_data <= rom[i_bus.addr[`BUS_ROM_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module bus_ram import bus_pkg::*; (
    input  wire             clk,
    input  wire             i_cs,
    input  wire cpu_bus_t   i_bus,
    input  wire phys_addr_t i_phys,
    output logic [7:0]      o_rd_data
);

    localparam int DEPTH = 2 ** `BUS_RAM_BITS;

    logic [7:0]               mem [DEPTH];
    logic [`BUS_RAM_BITS-1:0] idx;

    assign idx = i_phys[`BUS_RAM_BITS-1:0];     // range already checked by decoder

    // single port, read or write per access
    always_ff @(posedge clk) begin
        if (i_cs) begin
            if (i_bus.rwb) begin
                o_rd_data <= mem[idx];
            end else begin
                mem[idx] <= i_bus.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module addr_decode import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire cpu_bus_t   i_bus,
    input  wire phys_addr_t i_phys,
    output logic            o_ram_cs,
    output logic            o_rom_cs,
    output logic            o_io_cs,
    output logic            o_irq_cs,
    output logic            o_mm_lo_cs,
    output logic            o_mm_hi_cs,
    input  wire [7:0]       i_ram_rd,
    input  wire [7:0]       i_rom_rd,
    input  wire [7:0]       i_io_rd,
    input  wire [7:0]       i_irq_rd,
    input  wire [7:0]       i_mm_rd,
    output logic [7:0]      o_rd_data,
    output logic            o_rd_valid
);

    localparam phys_addr_t RAM_BASE = `BUS_RAM_BASE;

    dev_sel_e sel;
    dev_sel_e sel_q;        // device of the read in flight
    logic     rd_pend_q;

    always_comb begin
        sel = DEV_NONE;
        if (i_phys[23:`BUS_RAM_BITS] == RAM_BASE[23:`BUS_RAM_BITS]) begin
            sel = DEV_RAM;
        end else if (i_phys[23:12] == `BUS_ROM_PAGE) begin
            sel = DEV_ROM;
        end else if (i_phys[23:8] == `BUS_IO_PAGE) begin
            if (i_phys[7:1] == `BUS_IO_BOARD_OFS) begin
                sel = DEV_IO;
            end else if (i_phys[7:0] == `BUS_IO_IRQ_OFS) begin
                sel = DEV_IRQ;
            end else if (i_phys[7:4] == `BUS_IO_MM_LO_OFS) begin
                sel = DEV_MM_LO;
            end else if (i_phys[7:4] == `BUS_IO_MM_HI_OFS) begin
                sel = DEV_MM_HI;
            end
        end
    end

    assign o_ram_cs   = i_bus.valid && (sel == DEV_RAM);
    assign o_rom_cs   = i_bus.valid && (sel == DEV_ROM);
    assign o_io_cs    = i_bus.valid && (sel == DEV_IO);
    assign o_irq_cs   = i_bus.valid && (sel == DEV_IRQ);
    assign o_mm_lo_cs = i_bus.valid && (sel == DEV_MM_LO);
    assign o_mm_hi_cs = i_bus.valid && (sel == DEV_MM_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend_q <= 1'b0;
            sel_q     <= DEV_NONE;
        end else begin
            rd_pend_q <= i_bus.valid && i_bus.rwb;
            if (i_bus.valid && i_bus.rwb) begin
                sel_q <= sel;
            end
        end
    end

    always_comb begin
        case (sel_q)
            DEV_RAM:              o_rd_data = i_ram_rd;
            DEV_ROM:              o_rd_data = i_rom_rd;
            DEV_IO:               o_rd_data = i_io_rd;
            DEV_IRQ:              o_rd_data = i_irq_rd;
            DEV_MM_LO, DEV_MM_HI: o_rd_data = i_mm_rd;
            default:              o_rd_data = 8'hFF;   // unmapped
        endcase
    end

    assign o_rd_valid = rd_pend_q;

    // data valid only one cycle after a read strobe
    a_rd_valid_after_rd: assert property (
        @(posedge clk) disable iff (rst)
        o_rd_valid |-> $past(i_bus.valid && i_bus.rwb)
    );

endmodule

`default_nettype wire

// ==== src/memory_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module memory_mapper import bus_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire cpu_bus_t   i_bus,
    input  wire             i_lo_cs,
    input  wire             i_hi_cs,
    output logic [7:0]      o_rd_data,
    output phys_addr_t      o_phys
);

    logic [11:0] slot_q [`BUS_MM_SLOTS];
    logic [3:0]  reg_sel;
    logic [3:0]  slot_sel;
    logic        wr_en;
    logic        rd_en;

    assign reg_sel  = i_bus.addr[3:0];      // register index in the i/o window
    assign slot_sel = i_bus.addr[15:12];    // logical 4 KB page
    assign wr_en    = !i_bus.rwb;
    assign rd_en    = i_bus.rwb;

    // slot registers, identity map out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BUS_MM_SLOTS; i++) begin
                slot_q[i] <= 12'(i);
            end
        end else if (i_lo_cs && wr_en) begin
            slot_q[reg_sel][7:0] <= i_bus.wdata;
        end else if (i_hi_cs && wr_en) begin
            slot_q[reg_sel][11:8] <= i_bus.wdata[3:0];
        end
    end

    // register readback
    always_ff @(posedge clk) begin
        if (i_lo_cs && rd_en) begin
            o_rd_data <= slot_q[reg_sel][7:0];
        end else if (i_hi_cs && rd_en) begin
            o_rd_data <= {4'h0, slot_q[reg_sel][11:8]};
        end
    end

    // a write above is seen by the very next access
    assign o_phys = {slot_q[slot_sel], i_bus.addr[11:0]};

    // decoder must never select both register banks
    a_mm_cs_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(i_lo_cs && i_hi_cs)
    );

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // cpu side bus, sampled on every clk edge
    typedef struct packed {
        logic        valid;     // one-cycle access strobe
        logic        rwb;       // high = read
        logic [15:0] addr;      // logical address
        logic [7:0]  wdata;
    } cpu_bus_t;

    // mapped address, 12-bit page + 12-bit offset
    typedef logic [23:0] phys_addr_t;

    // device targeted by an access
    typedef enum logic [2:0] {
        DEV_NONE  = 3'd0,
        DEV_RAM   = 3'd1,
        DEV_ROM   = 3'd2,
        DEV_IO    = 3'd3,
        DEV_IRQ   = 3'd4,
        DEV_MM_LO = 3'd5,
        DEV_MM_HI = 3'd6
    } dev_sel_e;

endpackage

`default_nettype wire

// ==== include/bus_defs.svh ====
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// physical memory map, 24-bit addresses

// ram window, base plus address width
`define BUS_RAM_BASE        24'h000000
`define BUS_RAM_BITS        15

// i/o window is phys[23:8]
`define BUS_IO_PAGE         16'h00C0

// offsets inside the i/o window
`define BUS_IO_BOARD_OFS    7'h00       // phys[7:1], two bytes
`define BUS_IO_IRQ_OFS      8'h04       // phys[7:0]
`define BUS_IO_MM_LO_OFS    4'h1        // phys[7:4], 0x10..0x1f
`define BUS_IO_MM_HI_OFS    4'h2        // phys[7:4], 0x20..0x2f

// boot rom page is phys[23:12]
`define BUS_ROM_PAGE        12'h00F
`define BUS_ROM_BITS        5           // 32 bytes, mirrored

// mapper slots, one per 4 KB of logical space
`define BUS_MM_SLOTS        16

`endif
